/* logic/rob_pkg.sv */
package rob_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] areg_t;
	typedef logic [31:0] pc_t;

	typedef enum logic [1:0] {
		op_add = 2'd0,
		op_sub = 2'd1,
		op_xor = 2'd2,
		op_and = 2'd3
	} op_t;

	// extra cycles spent in the pool
	typedef logic [1:0] lat_t;

	function automatic logic [xlen-1:0] alu_result(
		input op_t op,
		input logic [xlen-1:0] a,
		input logic [xlen-1:0] b
	);
		logic [xlen-1:0] r;
		case (op)
			op_add: r = a + b;
			op_sub: r = a - b;
			op_xor: r = a ^ b;
			op_and: r = a & b;
			default: r = '0;
		endcase
		return r;
	endfunction

endpackage

/* logic/dispatch_stage.sv */
module dispatch_stage
	import rob_pkg::*;
#(
	parameter int DEPTH = 8,
	localparam int TW = $clog2(DEPTH) + 1
) (
	input logic clk,
	input logic reset,
	input logic [1:0] in_valid,
	input pc_t in_pc [2],
	input areg_t in_dst [2],
	input op_t in_op [2],
	input logic [xlen-1:0] in_a [2],
	input logic [xlen-1:0] in_b [2],
	input lat_t in_lat [2],
	output logic in_ready,
	input logic [TW-1:0] alloc_tag [2],
	input logic rob_full,
	output logic [1:0] alloc_valid,
	output pc_t alloc_pc [2],
	output areg_t alloc_dst [2],
	output logic [1:0] issue_valid,
	output logic [TW-1:0] issue_tag [2],
	output op_t issue_op [2],
	output logic [xlen-1:0] issue_a [2],
	output logic [xlen-1:0] issue_b [2],
	output lat_t issue_lat [2]
);

	logic [1:0] disp_valid;
	pc_t disp_pc [2];
	areg_t disp_dst [2];
	op_t disp_op [2];
	logic [xlen-1:0] disp_a [2];
	logic [xlen-1:0] disp_b [2];
	lat_t disp_lat [2];

	// lane feeding slot 0, so a lone lane 1 moves down
	logic src0;

	// room for the group already held plus a full new one
	assign in_ready = !rob_full;
	assign src0 = !in_valid[0];

	always_ff @(posedge clk) begin
		if (reset) begin
			disp_valid <= 2'b00;
		end else if (in_ready) begin
			disp_valid <= {&in_valid, |in_valid};
		end else begin
			disp_valid <= 2'b00;
		end
	end

	always_ff @(posedge clk) begin
		disp_pc[0] <= in_pc[src0];
		disp_dst[0] <= in_dst[src0];
		disp_op[0] <= in_op[src0];
		disp_a[0] <= in_a[src0];
		disp_b[0] <= in_b[src0];
		disp_lat[0] <= in_lat[src0];
		disp_pc[1] <= in_pc[1];
		disp_dst[1] <= in_dst[1];
		disp_op[1] <= in_op[1];
		disp_a[1] <= in_a[1];
		disp_b[1] <= in_b[1];
		disp_lat[1] <= in_lat[1];
	end

	assign alloc_valid = disp_valid;
	assign alloc_pc = disp_pc;
	assign alloc_dst = disp_dst;

	// pool gets the same tags the buffer hands out
	assign issue_valid = disp_valid;
	assign issue_tag = alloc_tag;
	assign issue_op = disp_op;
	assign issue_a = disp_a;
	assign issue_b = disp_b;
	assign issue_lat = disp_lat;

endmodule

/* logic/reorder_buffer.sv */
module reorder_buffer
	import rob_pkg::*;
#(
	parameter int DEPTH = 8,
	localparam int TW = $clog2(DEPTH) + 1
) (
	input logic clk,
	input logic reset,
	input logic [1:0] alloc_valid,
	input pc_t alloc_pc [2],
	input areg_t alloc_dst [2],
	output logic [TW-1:0] alloc_tag [2],
	output logic rob_full,
	input logic [1:0] done_valid,
	input logic [TW-1:0] done_tag [2],
	input logic [xlen-1:0] done_data [2],
	output logic [1:0] rel_valid,
	output pc_t rel_pc [2],
	output areg_t rel_dst [2],
	output logic [xlen-1:0] rel_data [2]
);

	typedef logic [TW-2:0] idx_t;

	pc_t pc_mem [DEPTH];
	areg_t dst_mem [DEPTH];
	logic [xlen-1:0] data_mem [DEPTH];
	logic [DEPTH-1:0] complete;

	// msb is the wrap bit
	logic [TW-1:0] head;
	logic [TW-1:0] tail;
	logic [TW-1:0] head_next;
	logic [TW-1:0] used;
	logic [TW:0] pending;
	logic [1:0] alloc_count;
	logic [1:0] rel_count;
	idx_t head_idx [2];
	idx_t alloc_idx [2];
	idx_t done_idx [2];
	logic [TW-1:0] done_age [2];

	assign alloc_tag[0] = tail;
	assign alloc_tag[1] = tail + 1'b1;
	assign head_next = head + 1'b1;

	assign used = tail - head;
	assign alloc_count = {1'b0, alloc_valid[0]} + {1'b0, alloc_valid[1]};
	assign rel_count = {1'b0, rel_valid[0]} + {1'b0, rel_valid[1]};

	// entries being written this cycle count as taken
	assign pending = {1'b0, used} + {{(TW - 1){1'b0}}, alloc_count};
	assign rob_full = pending > (TW + 1)'(DEPTH - 2);

	always_comb begin
		head_idx[0] = head[TW-2:0];
		head_idx[1] = head_next[TW-2:0];
		for (int i = 0; i < 2; i++) begin
			alloc_idx[i] = alloc_tag[i][TW-2:0];
			done_idx[i] = done_tag[i][TW-2:0];
			done_age[i] = done_tag[i] - head;
		end
	end

	// in-order release, at most two from the head
	assign rel_valid[0] = (head != tail) && complete[head_idx[0]];
	assign rel_valid[1] = rel_valid[0] && (head_next != tail) && complete[head_idx[1]];

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rel_pc[i] = pc_mem[head_idx[i]];
			rel_dst[i] = dst_mem[head_idx[i]];
			rel_data[i] = data_mem[head_idx[i]];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			complete <= '0;
		end else begin
			head <= head + {{(TW - 2){1'b0}}, rel_count};
			tail <= tail + {{(TW - 2){1'b0}}, alloc_count};
			for (int i = 0; i < 2; i++) begin
				if (rel_valid[i]) begin
					complete[head_idx[i]] <= 1'b0;
				end
			end
			for (int i = 0; i < 2; i++) begin
				if (alloc_valid[i]) begin
					complete[alloc_idx[i]] <= 1'b0;
				end
			end
			for (int i = 0; i < 2; i++) begin
				if (done_valid[i]) begin
					complete[done_idx[i]] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (alloc_valid[i]) begin
				pc_mem[alloc_idx[i]] <= alloc_pc[i];
				dst_mem[alloc_idx[i]] <= alloc_dst[i];
			end
		end
		for (int i = 0; i < 2; i++) begin
			if (done_valid[i]) begin
				data_mem[done_idx[i]] <= done_data[i];
			end
		end
	end

	for (genvar i = 0; i < 2; i++) begin : g_done_chk
		// the pool only finishes work the buffer still holds
		a_done_in_flight: assert property (@(posedge clk) disable iff (reset)
			done_valid[i] |-> done_age[i] < used);
		a_done_once: assert property (@(posedge clk) disable iff (reset)
			done_valid[i] |-> !complete[done_idx[i]]);
	end

endmodule

/* logic/exec_pool.sv */
module exec_pool
	import rob_pkg::*;
#(
	parameter int DEPTH = 8,
	localparam int TW = $clog2(DEPTH) + 1
) (
	input logic clk,
	input logic reset,
	input logic [1:0] issue_valid,
	input logic [TW-1:0] issue_tag [2],
	input op_t issue_op [2],
	input logic [xlen-1:0] issue_a [2],
	input logic [xlen-1:0] issue_b [2],
	input lat_t issue_lat [2],
	output logic [1:0] done_valid,
	output logic [TW-1:0] done_tag [2],
	output logic [xlen-1:0] done_data [2]
);

	typedef logic [TW-2:0] idx_t;

	logic [DEPTH-1:0] busy;
	logic [DEPTH-1:0] wrap;
	lat_t cnt [DEPTH];
	logic [xlen-1:0] res [DEPTH];
	logic [DEPTH-1:0] expired;
	idx_t sel [2];

	always_comb begin
		for (int s = 0; s < DEPTH; s++) begin
			expired[s] = busy[s] && (cnt[s] == '0);
		end
	end

	// two lowest expired slots win, the rest hold at zero
	always_comb begin
		done_valid = 2'b00;
		sel[0] = '0;
		sel[1] = '0;
		for (int s = 0; s < DEPTH; s++) begin
			if (expired[s]) begin
				if (!done_valid[0]) begin
					done_valid[0] = 1'b1;
					sel[0] = idx_t'(s);
				end else if (!done_valid[1]) begin
					done_valid[1] = 1'b1;
					sel[1] = idx_t'(s);
				end
			end
		end
		for (int i = 0; i < 2; i++) begin
			done_tag[i] = {wrap[sel[i]], sel[i]};
			done_data[i] = res[sel[i]];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
		end else begin
			for (int s = 0; s < DEPTH; s++) begin
				if (busy[s] && cnt[s] != '0) begin
					cnt[s] <= cnt[s] - 1'b1;
				end
			end
			for (int i = 0; i < 2; i++) begin
				if (done_valid[i]) begin
					busy[sel[i]] <= 1'b0;
				end
			end
			for (int i = 0; i < 2; i++) begin
				if (issue_valid[i]) begin
					busy[issue_tag[i][TW-2:0]] <= 1'b1;
					wrap[issue_tag[i][TW-2:0]] <= issue_tag[i][TW-1];
					cnt[issue_tag[i][TW-2:0]] <= issue_lat[i];
					res[issue_tag[i][TW-2:0]] <= alu_result(issue_op[i], issue_a[i], issue_b[i]);
				end
			end
		end
	end

	for (genvar i = 0; i < 2; i++) begin : g_issue_chk
		// a tag comes back only after the buffer released it
		a_issue_free_slot: assert property (@(posedge clk) disable iff (reset)
			issue_valid[i] |-> !busy[issue_tag[i][TW-2:0]]);
	end

endmodule

/* logic/retire_stage.sv */
module retire_stage
	import rob_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [1:0] rel_valid,
	input pc_t rel_pc [2],
	input areg_t rel_dst [2],
	input logic [xlen-1:0] rel_data [2],
	output logic [1:0] retire_valid,
	output pc_t retire_pc [2],
	output areg_t retire_dst [2],
	output logic [xlen-1:0] retire_data [2],
	output logic [31:0] retired_count
);

	logic [1:0] rel_count;

	assign rel_count = {1'b0, rel_valid[0]} + {1'b0, rel_valid[1]};

	always_ff @(posedge clk) begin
		if (reset) begin
			retire_valid <= 2'b00;
			retired_count <= '0;
		end else begin
			retire_valid <= rel_valid;
			retired_count <= retired_count + {30'd0, rel_count};
		end
	end

	always_ff @(posedge clk) begin
		retire_pc <= rel_pc;
		retire_dst <= rel_dst;
		retire_data <= rel_data;
	end

endmodule

/* logic/ooo_core.sv */
module ooo_core
	import rob_pkg::*;
#(
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic reset,
	input logic [1:0] in_valid,
	input pc_t in_pc [2],
	input areg_t in_dst [2],
	input op_t in_op [2],
	input logic [xlen-1:0] in_a [2],
	input logic [xlen-1:0] in_b [2],
	input lat_t in_lat [2],
	output logic in_ready,
	output logic [1:0] retire_valid,
	output pc_t retire_pc [2],
	output areg_t retire_dst [2],
	output logic [xlen-1:0] retire_data [2],
	output logic [31:0] retired_count
);

	localparam int TW = $clog2(DEPTH) + 1;

	logic [TW-1:0] alloc_tag [2];
	logic rob_full;
	logic [1:0] alloc_valid;
	pc_t alloc_pc [2];
	areg_t alloc_dst [2];
	logic [1:0] issue_valid;
	logic [TW-1:0] issue_tag [2];
	op_t issue_op [2];
	logic [xlen-1:0] issue_a [2];
	logic [xlen-1:0] issue_b [2];
	lat_t issue_lat [2];
	logic [1:0] done_valid;
	logic [TW-1:0] done_tag [2];
	logic [xlen-1:0] done_data [2];
	logic [1:0] rel_valid;
	pc_t rel_pc [2];
	areg_t rel_dst [2];
	logic [xlen-1:0] rel_data [2];

	dispatch_stage #(.DEPTH(DEPTH)) i_dispatch (.*);

	reorder_buffer #(.DEPTH(DEPTH)) i_rob (.*);

	exec_pool #(.DEPTH(DEPTH)) i_pool (.*);

	retire_stage i_retire (.*);

endmodule

/* verification/retire_checks.sv */
module retire_checks
	import rob_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_ready,
	input logic [1:0] retire_valid,
	input pc_t retire_pc [2],
	input areg_t retire_dst [2],
	input logic [xlen-1:0] retire_data [2],
	input logic [31:0] retired_count,
	input int ref_count,
	input pc_t exp_pc [2],
	input areg_t exp_dst [2],
	input logic [xlen-1:0] exp_data [2]
);

	timeunit 1ns;
	timeprecision 1ps;

	int mismatch_errors = 0;
	int other_errors = 0;

	for (genvar i = 0; i < 2; i++) begin : g_lane
		a_pc: assert property (@(posedge clk) disable iff (reset)
			retire_valid[i] |-> retire_pc[i] == exp_pc[i])
		else begin
			mismatch_errors++;
			$display("Mismatch at %0t ns: retire_pc[%0d] got %h, expected %h",
				$time, i, $sampled(retire_pc[i]), $sampled(exp_pc[i]));
		end
		a_dst: assert property (@(posedge clk) disable iff (reset)
			retire_valid[i] |-> retire_dst[i] == exp_dst[i])
		else begin
			mismatch_errors++;
			$display("Mismatch at %0t ns: retire_dst[%0d] got %0d, expected %0d",
				$time, i, $sampled(retire_dst[i]), $sampled(exp_dst[i]));
		end
		a_data: assert property (@(posedge clk) disable iff (reset)
			retire_valid[i] |-> retire_data[i] == exp_data[i])
		else begin
			mismatch_errors++;
			$display("Mismatch at %0t ns: retire_data[%0d] got %h, expected %h",
				$time, i, $sampled(retire_data[i]), $sampled(exp_data[i]));
		end
		// nothing retires that was never accepted
		a_known: assert property (@(posedge clk) disable iff (reset)
			retire_valid[i] |-> ref_count > i)
		else begin
			other_errors++;
			$display("Lane %0d retired at %0t ns with no instruction left to retire", i, $time);
		end
	end

	a_lane_order: assert property (@(posedge clk) disable iff (reset)
		retire_valid[1] |-> retire_valid[0])
	else begin
		other_errors++;
		$display("Lane 1 retired without lane 0 at %0t ns", $time);
	end

	// state during reset and on the first cycle out of it
	a_reset_ready: assert property (@(posedge clk) $past(reset) |-> in_ready)
	else begin
		mismatch_errors++;
		$display("Mismatch at %0t ns: in_ready got %b, expected 1", $time, $sampled(in_ready));
	end
	a_reset_valid: assert property (@(posedge clk) $past(reset) |-> retire_valid == 2'b00)
	else begin
		mismatch_errors++;
		$display("Mismatch at %0t ns: retire_valid got %b, expected 00",
			$time, $sampled(retire_valid));
	end
	a_reset_count: assert property (@(posedge clk) $past(reset) |-> retired_count == '0)
	else begin
		mismatch_errors++;
		$display("Mismatch at %0t ns: retired_count got %0d, expected 0",
			$time, $sampled(retired_count));
	end

endmodule

/* verification/ooo_core_tb.sv */
module ooo_core_tb
	import rob_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic reset;
	logic [1:0] in_valid;
	pc_t in_pc [2];
	areg_t in_dst [2];
	op_t in_op [2];
	logic [xlen-1:0] in_a [2];
	logic [xlen-1:0] in_b [2];
	lat_t in_lat [2];
	logic in_ready;
	logic [1:0] retire_valid;
	pc_t retire_pc [2];
	areg_t retire_dst [2];
	logic [xlen-1:0] retire_data [2];
	logic [31:0] retired_count;

	// reference queue, oldest accepted instruction first
	pc_t ref_pc [$];
	areg_t ref_dst [$];
	logic [xlen-1:0] ref_data [$];
	int ref_count;
	pc_t exp_pc [2];
	areg_t exp_dst [2];
	logic [xlen-1:0] exp_data [2];

	int seed = 61519;
	int accepted = 0;
	int cycle_count = 0;
	int end_mismatches = 0;
	int end_other = 0;
	bit saw_stall = 1'b0;
	pc_t next_pc;

	ooo_core #(.DEPTH(8)) i_dut (.*);

	retire_checks i_checks (.*);

	// bit by bit, subtract adds the two's complement of b
	function automatic logic [xlen-1:0] predict(op_t op, logic [xlen-1:0] a, logic [xlen-1:0] b);
		logic [xlen-1:0] r;
		logic [xlen-1:0] y;
		logic c;
		y = (op == op_sub) ? ~b : b;
		c = (op == op_sub);
		for (int k = 0; k < xlen; k++) begin
			case (op)
				op_xor: r[k] = a[k] != b[k];
				op_and: r[k] = a[k] && b[k];
				default: begin
					r[k] = a[k] ^ y[k] ^ c;
					c = (a[k] & y[k]) | (c & (a[k] ^ y[k]));
				end
			endcase
		end
		return r;
	endfunction

	task automatic pop_reference();
		void'(ref_pc.pop_front());
		void'(ref_dst.pop_front());
		void'(ref_data.pop_front());
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// retirements leave the queue before this edge's acceptances join it
	always @(posedge clk) begin
		cycle_count++;
		if (!reset) begin
			for (int l = 0; l < 2; l++) begin
				if (retire_valid[l] && ref_pc.size() > 0) begin
					pop_reference();
				end
			end
			if (!in_ready) begin
				saw_stall = 1'b1;
			end
			for (int l = 0; l < 2; l++) begin
				if (in_ready && in_valid[l]) begin
					ref_pc.push_back(in_pc[l]);
					ref_dst.push_back(in_dst[l]);
					ref_data.push_back(predict(in_op[l], in_a[l], in_b[l]));
					accepted++;
				end
			end
		end
		ref_count = ref_pc.size();
		for (int l = 0; l < 2; l++) begin
			exp_pc[l] = (ref_count > l) ? ref_pc[l] : '0;
			exp_dst[l] = (ref_count > l) ? ref_dst[l] : '0;
			exp_data[l] = (ref_count > l) ? ref_data[l] : '0;
		end
		if (cycle_count > 40 * accepted + 200) begin
			$display("Timeout after %0d cycles, %0d instructions never retired",
				cycle_count, ref_count);
			$display("Errors: %0d mismatches, %0d other",
				i_checks.mismatch_errors + end_mismatches, i_checks.other_errors + end_other);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic set_lane(input int l, input logic v, input op_t op, input lat_t lat);
		in_valid[l] = v;
		in_pc[l] = next_pc;
		in_dst[l] = areg_t'($random(seed));
		in_op[l] = op;
		in_a[l] = $random(seed);
		in_b[l] = $random(seed);
		in_lat[l] = lat;
		if (v) begin
			next_pc = next_pc + 32'd4;
		end
	endtask

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic send_group(input logic [1:0] v, input op_t op0, input lat_t lat0,
			input op_t op1, input lat_t lat1);
		set_lane(0, v[0], op0, lat0);
		set_lane(1, v[1], op1, lat1);
		while (!in_ready) begin
			@(negedge clk);
		end
		@(negedge clk);
		in_valid = 2'b00;
	endtask

	task automatic send_random_group();
		logic [1:0] v;
		v = 2'd1 + 2'($unsigned($random(seed)) % 3);
		send_group(v, op_t'(2'($random(seed))), lat_t'($random(seed)),
			op_t'(2'($random(seed))), lat_t'($random(seed)));
	endtask

	initial begin
		reset = 1'b1;
		next_pc = 32'h0000_1000;
		set_lane(0, 1'b0, op_add, 2'd0);
		set_lane(1, 1'b0, op_add, 2'd0);
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// every op at every latency class
		for (int i = 0; i < 16; i++) begin
			send_group(2'b11, op_t'(2'(i)), lat_t'(i / 4), op_t'(2'(i + 1)), lat_t'(3 - i / 4));
		end
		// slow oldest instruction, quick younger ones
		send_group(2'b01, op_sub, 2'd3, op_add, 2'd0);
		send_group(2'b11, op_xor, 2'd0, op_and, 2'd0);
		send_group(2'b11, op_add, 2'd0, op_sub, 2'd1);
		// full groups at the longest latency back up the buffer
		for (int i = 0; i < 12; i++) begin
			send_group(2'b11, op_add, 2'd3, op_xor, 2'd3);
		end
		send_group(2'b10, op_and, 2'd1, op_and, 2'd2);
		send_group(2'b01, op_sub, 2'd2, op_xor, 2'd0);
		repeat (24) send_random_group();
		while (ref_pc.size() != 0) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		assert (saw_stall) else begin
			end_other++;
			$display("in_ready never went low while the buffer was being filled");
		end
		assert (retired_count == 32'(accepted)) else begin
			end_mismatches++;
			$display("Mismatch at %0t ns: retired_count got %0d, expected %0d",
				$time, retired_count, accepted);
		end
		$display("Errors: %0d mismatches, %0d other",
			i_checks.mismatch_errors + end_mismatches, i_checks.other_errors + end_other);
		if (i_checks.mismatch_errors + i_checks.other_errors + end_mismatches + end_other == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* sources.f */
logic/rob_pkg.sv
logic/dispatch_stage.sv
logic/reorder_buffer.sv
logic/exec_pool.sv
logic/retire_stage.sv
logic/ooo_core.sv
verification/retire_checks.sv
verification/ooo_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP := ooo_core_tb
FILELIST := sources.f
FLAGS := --binary --assert -Wno-fatal -j 0
OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))
LOG := sim.log
PASS_MSG := Done: no errors

.PHONY: all run check clean

all: check

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)

check: run
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
